// ==== fx2_pkg.sv ====
package fx2_pkg;

	// FX2 FIFOADR codes for the four slave FIFOs
	// Only the control pair carries traffic here
	// EVENT_INBOUND is the resting address when no transfer runs
	typedef enum logic [1:0] {
		CTRL_INBOUND   = 2'd0,
		EVENT_INBOUND  = 2'd1,
		CTRL_OUTBOUND  = 2'd2,
		EVENT_OUTBOUND = 2'd3
	} fifo_addr_e;

	// Largest packet the FX2 endpoint buffer holds
	localparam int PKT_MAX_BYTES = 512;

	// Width of the write byte counter, counts 0 to PKT_MAX_BYTES-1
	localparam int PKT_COUNT_BITS = $clog2(PKT_MAX_BYTES);

	// FX2 status flags, converted to active high
	// Raw flags come straight off the pins
	// The _q flags are one cycle late and have a reset value
	typedef struct packed {
		// EP2 empty, raw
		logic in_empty;
		// EP2 empty, registered
		logic in_empty_q;
		// EP6 almost full, registered
		logic out_full_q;
		// EP6 almost full, raw
		logic out_full;
	} fx2_flags_t;

	// Strobe enables, active high, one cycle ahead of the pins
	// sloe high means the FX2 owns the FD bus
	typedef struct packed {
		logic slrd;
		logic slwr;
		logic pktend;
		logic sloe;
	} fx2_strobes_t;

endpackage

// ==== usb_ctrl_pkg.sv ====
package usb_ctrl_pkg;

	// Read/write sequencer states
	typedef enum logic [3:0] {
		// Waiting for work, address rests
		IDLE,
		// Drive FIFOADR, it needs setup time before any strobe
		ASSERT_ADDR,
		// Address settles, a write starts its first strobe here
		ADDR_WAIT,
		// Read strobe enabled, FD not yet valid
		SLRD_ENABLE,
		// First SLRD on the pin
		READ_WAIT,
		// Streaming reads
		READ,
		// Inbound FIFO full, SLRD held off
		READ_PAUSE,
		// Restart SLRD before going back to READ
		READ_RESUME,
		// Streaming writes
		WRITE,
		// Local data ran out inside an open packet
		WRITE_WAIT,
		// Drop address and strobes
		DONE
	} seq_state_e;

	// Direction of the current FX2 transfer
	typedef enum logic {
		TXN_READ,
		TXN_WRITE
	} txn_e;

	// Local FIFO status and outbound data into the bridge
	// dat is first-word-fall-through, valid while empty is low
	// packet high keeps the packet open when data runs out
	// full is from the inbound FIFO, which takes two more writes after it rises
	typedef struct packed {
		logic [7:0] dat;
		logic empty;
		logic packet;
		logic full;
	} ctrl_src_t;

	// Bridge to the local FIFOs
	// wr pushes dat into the inbound FIFO
	// rd pops the outbound FIFO
	typedef struct packed {
		logic [7:0] dat;
		logic wr;
		logic rd;
	} ctrl_sink_t;

endpackage

// ==== fx2_pin_io.sv ====
`timescale 1ns/10ps

module fx2_pin_io #(
	parameter string PINPOL = "NEGATIVE"
) (
	input  logic                  CLK,
	input  logic                  rst_i,
	// EP2 empty
	input  logic                  flaga_i,
	// EP6 almost full
	input  logic                  flagd_i,
	input  fx2_pkg::fx2_strobes_t strobes_i,
	input  logic                  fd_latch_i,
	input  logic [7:0]            out_dat_i,
	inout  wire  [7:0]            fd_io,
	output logic                  sloe_o,
	output logic                  slrd_o,
	output logic                  slwr_o,
	output logic                  pktend_o,
	output fx2_pkg::fx2_flags_t   flags_o,
	output logic [7:0]            in_dat_o
);
	import fx2_pkg::*;

	// Invert everything unless the pins are active high
	localparam logic PIN_INV = (PINPOL == "POSITIVE") ? 1'b0 : 1'b1;

	logic         in_empty;
	logic         out_full;
	logic         in_empty_q;
	logic         out_full_q;
	fx2_strobes_t strobes_q;

	// Flags to internal active-high sense
	assign in_empty = flaga_i ^ PIN_INV;
	assign out_full = flagd_i ^ PIN_INV;

	// Registered flags
	// Out of reset EP2 looks empty and EP6 not full, so nothing starts
	always_ff @(posedge CLK) begin
		if (rst_i) begin
			in_empty_q <= 1'b1;
			out_full_q <= 1'b0;
		end else begin
			in_empty_q <= in_empty;
			out_full_q <= out_full;
		end
	end

	assign flags_o = '{
		in_empty:   in_empty,
		in_empty_q: in_empty_q,
		out_full_q: out_full_q,
		out_full:   out_full
	};

	// Output register stage for every strobe
	// Each pin lags its enable by one clock
	always_ff @(posedge CLK) begin
		if (rst_i) begin
			strobes_q <= '0;
		end else begin
			strobes_q <= strobes_i;
		end
	end

	// Back to pin polarity
	assign slrd_o   = strobes_q.slrd ^ PIN_INV;
	assign slwr_o   = strobes_q.slwr ^ PIN_INV;
	assign pktend_o = strobes_q.pktend ^ PIN_INV;
	// Active SLOE lets the FX2 drive FD
	assign sloe_o   = strobes_q.sloe ^ PIN_INV;

	// We own FD whenever the FX2 output enable is off
	// Uses the registered sloe so the handover lines up with the SLOE pin
	assign fd_io = strobes_q.sloe ? 8'hzz : out_dat_i;

	// Input data register
	// Sequencer only latches on cycles where SLRD actually pops a byte
	always_ff @(posedge CLK) begin
		if (fd_latch_i) begin
			in_dat_o <= fd_io;
		end
	end

endmodule

// ==== usb_write_packetizer.sv ====
`timescale 1ns/10ps

module usb_write_packetizer (
	input  logic       CLK,
	input  logic       rst_i,
	// SLWR enable from the sequencer, one clock ahead of the pin
	input  logic       slwr_en_i,
	input  logic       data_load_i,
	input  logic [7:0] dat_i,
	output logic [7:0] out_dat_o,
	output logic       count_at_max_o
);
	import fx2_pkg::*;

	localparam logic [PKT_COUNT_BITS-1:0] COUNT_MAX = PKT_COUNT_BITS'(PKT_MAX_BYTES - 1);

	logic [PKT_COUNT_BITS-1:0] count;

	// Counts enabled write cycles in the current burst
	// Any gap in SLWR starts the count again
	always_ff @(posedge CLK) begin
		if (rst_i) begin
			count <= '0;
		end else if (slwr_en_i) begin
			count <= count + 1'b1;
		end else begin
			count <= '0;
		end
	end

	// At COUNT_MAX the current enable carries byte 512
	assign count_at_max_o = (count == COUNT_MAX);

	// Outbound byte register, drives FD one clock after the FIFO pop
	always_ff @(posedge CLK) begin
		if (data_load_i) begin
			out_dat_o <= dat_i;
		end
	end

endmodule

// ==== usb_txn_sequencer.sv ====
`timescale 1ns/10ps

module usb_txn_sequencer (
	input  logic                  CLK,
	input  logic                  rst_i,
	input  fx2_pkg::fx2_flags_t   flags_i,
	input  logic                  ctrl_empty_i,
	input  logic                  ctrl_packet_i,
	input  logic                  ctrl_full_i,
	input  logic                  count_at_max_i,
	output fx2_pkg::fx2_strobes_t strobes_o,
	output logic                  fd_latch_o,
	output logic                  data_load_o,
	output logic                  ctrl_wr_o,
	output logic                  ctrl_rd_o,
	output fx2_pkg::fifo_addr_e   fifoadr_o
);
	import fx2_pkg::*;
	import usb_ctrl_pkg::*;

	seq_state_e state;
	txn_e       txn;
	logic       is_write;
	logic       read_ok;
	logic       write_ok;
	logic       slrd_en;
	logic       xfer_en;
	logic       pktend_en;
	logic       sloe_en;
	logic       delayed_pktend;
	logic       slrd_q;
	logic       pop_valid;
	logic       wr_q;

	assign is_write = (txn == TXN_WRITE);

	// Start a read when EP2 has data and the local FIFO has room
	assign read_ok = !flags_i.in_empty_q && !ctrl_full_i;
	// Start a write only when EP6 is clear on both the raw and registered flag
	assign write_ok = !flags_i.out_full_q && !flags_i.out_full && !ctrl_empty_i;

	// Transaction choice, made in IDLE only
	// Reads win over writes
	always_ff @(posedge CLK) begin
		if (rst_i) begin
			txn       <= TXN_READ;
			fifoadr_o <= EVENT_INBOUND;
		end else if (state == IDLE) begin
			if (read_ok) begin
				txn       <= TXN_READ;
				fifoadr_o <= CTRL_INBOUND;
			end else if (write_ok) begin
				txn       <= TXN_WRITE;
				fifoadr_o <= CTRL_OUTBOUND;
			end else begin
				fifoadr_o <= EVENT_INBOUND;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (rst_i) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (read_ok || write_ok) begin
						state <= ASSERT_ADDR;
					end
				end
				ASSERT_ADDR: state <= ADDR_WAIT;
				ADDR_WAIT:   state <= is_write ? WRITE : SLRD_ENABLE;
				SLRD_ENABLE: state <= READ_WAIT;
				READ_WAIT:   state <= READ;
				// Raw empty ends the read, local full parks it
				READ: begin
					if (flags_i.in_empty) begin
						state <= DONE;
					end else if (ctrl_full_i) begin
						state <= READ_PAUSE;
					end
				end
				// Pending outbound data gets serviced while we wait for room
				READ_PAUSE: begin
					if (!ctrl_full_i) begin
						state <= READ_RESUME;
					end else if (!ctrl_empty_i) begin
						state <= IDLE;
					end
				end
				READ_RESUME: state <= READ;
				WRITE: begin
					if (flags_i.out_full_q || count_at_max_i) begin
						state <= DONE;
					end else if (ctrl_empty_i) begin
						state <= ctrl_packet_i ? WRITE_WAIT : DONE;
					end
				end
				WRITE_WAIT: begin
					if (!ctrl_empty_i) begin
						state <= WRITE;
					end
				end
				DONE:    state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// SLRD enable, held off while the local FIFO is full
	assign slrd_en = ((state == SLRD_ENABLE) || (state == READ_WAIT) ||
		(state == READ) || (state == READ_RESUME)) && !ctrl_full_i;

	// Copy of the SLRD pin
	// A pop happens when the pin is active and EP2 has a byte
	always_ff @(posedge CLK) begin
		if (rst_i) begin
			slrd_q <= 1'b0;
			wr_q   <= 1'b0;
		end else begin
			slrd_q <= slrd_en;
			wr_q   <= pop_valid;
		end
	end

	assign pop_valid = slrd_q && !flags_i.in_empty;
	// Every popped byte is latched once and pushed on the next clock
	assign fd_latch_o = pop_valid;
	assign ctrl_wr_o  = wr_q;

	// One outbound byte per cycle
	// Starts in ADDR_WAIT so SLWR meets the first byte on FD
	assign xfer_en = is_write && ((state == ADDR_WAIT) || (state == WRITE)) &&
		!ctrl_empty_i && !flags_i.out_full_q;
	assign ctrl_rd_o   = xfer_en;
	assign data_load_o = xfer_en;

	// PKTEND one cycle after the 512th SLWR enable
	always_ff @(posedge CLK) begin
		if (rst_i) begin
			delayed_pktend <= 1'b0;
		end else begin
			delayed_pktend <= (state == WRITE) && count_at_max_i && xfer_en;
		end
	end

	// Closed packet ran dry, or EP6 almost full
	assign pktend_en = ((state == WRITE) &&
		((ctrl_empty_i && !ctrl_packet_i) || flags_i.out_full_q)) || delayed_pktend;

	// FX2 drives FD only for the length of a read
	assign sloe_en = !is_write && (state != IDLE);

	assign strobes_o = '{
		slrd:   slrd_en,
		slwr:   xfer_en,
		pktend: pktend_en,
		sloe:   sloe_en
	};

endmodule

// ==== usb_ctrl_bridge.sv ====
`timescale 1ns/10ps

module usb_ctrl_bridge #(
	parameter string PINPOL = "NEGATIVE"
) (
	input  logic                     CLK,
	input  logic                     rst_i,
	input  logic                     flaga_i,
	input  logic                     flagd_i,
	output logic                     sloe_o,
	output logic                     slrd_o,
	output logic                     slwr_o,
	output logic                     pktend_o,
	output fx2_pkg::fifo_addr_e      fifoadr_o,
	inout  wire  [7:0]               fd_io,
	input  usb_ctrl_pkg::ctrl_src_t  ctrl_src_i,
	output usb_ctrl_pkg::ctrl_sink_t ctrl_sink_o
);
	import fx2_pkg::*;

	fx2_flags_t   flags;
	fx2_strobes_t strobes;
	logic         fd_latch;
	logic         data_load;
	logic         ctrl_wr;
	logic         ctrl_rd;
	logic         count_at_max;
	logic [7:0]   out_dat;
	logic [7:0]   in_dat;

	// Pin polarity, flag and strobe registers, FD bus
	fx2_pin_io #(
		.PINPOL(PINPOL)
	) fx2_pin_io_i (
		.CLK       (CLK),
		.rst_i     (rst_i),
		.flaga_i   (flaga_i),
		.flagd_i   (flagd_i),
		.strobes_i (strobes),
		.fd_latch_i(fd_latch),
		.out_dat_i (out_dat),
		.fd_io     (fd_io),
		.sloe_o    (sloe_o),
		.slrd_o    (slrd_o),
		.slwr_o    (slwr_o),
		.pktend_o  (pktend_o),
		.flags_o   (flags),
		.in_dat_o  (in_dat)
	);

	// Read/write FSM
	usb_txn_sequencer usb_txn_sequencer_i (
		.CLK           (CLK),
		.rst_i         (rst_i),
		.flags_i       (flags),
		.ctrl_empty_i  (ctrl_src_i.empty),
		.ctrl_packet_i (ctrl_src_i.packet),
		.ctrl_full_i   (ctrl_src_i.full),
		.count_at_max_i(count_at_max),
		.strobes_o     (strobes),
		.fd_latch_o    (fd_latch),
		.data_load_o   (data_load),
		.ctrl_wr_o     (ctrl_wr),
		.ctrl_rd_o     (ctrl_rd),
		.fifoadr_o     (fifoadr_o)
	);

	// Packet length limit and outbound byte
	usb_write_packetizer usb_write_packetizer_i (
		.CLK           (CLK),
		.rst_i         (rst_i),
		.slwr_en_i     (strobes.slwr),
		.data_load_i   (data_load),
		.dat_i         (ctrl_src_i.dat),
		.out_dat_o     (out_dat),
		.count_at_max_o(count_at_max)
	);

	// Inbound bytes come straight from the FD input register
	assign ctrl_sink_o = '{dat: in_dat, wr: ctrl_wr, rd: ctrl_rd};

endmodule

// ==== tb_usb_ctrl_bridge.sv ====
`timescale 1ns/10ps

module tb_usb_ctrl_bridge;
	import fx2_pkg::*;
	import usb_ctrl_pkg::*;

	localparam int TIMEOUT  = 4000;
	localparam int LEN_BITS = PKT_COUNT_BITS + 1;

	// What a wait loop is waiting for
	typedef enum {
		WAIT_INBOUND,
		WAIT_PKTEND,
		WAIT_REST
	} wait_e;

	logic       CLK = 1'b0;
	logic       rst_i;
	logic       flaga_i;
	logic       flagd_i;
	logic       sloe_o;
	logic       slrd_o;
	logic       slwr_o;
	logic       pktend_o;
	fifo_addr_e fifoadr_o;
	wire  [7:0] fd_io;
	ctrl_src_t  ctrl_src_i;
	ctrl_sink_t ctrl_sink_o;

	// Model outputs driven on the rising edge
	logic [7:0] fd_val;
	logic [7:0] out_head;
	logic       out_empty;
	logic       pkt_open;
	logic       in_full;

	// EP2 source, EP6 capture, local outbound source, local inbound capture
	logic [7:0]          ep2_q[$];
	logic [7:0]          ep6_q[$];
	logic [7:0]          out_q[$];
	logic [7:0]          in_cap[$];
	logic [7:0]          exp_q[$];
	logic [7:0]          got_q[$];
	logic [LEN_BITS-1:0] pkt_lens[$];
	logic [LEN_BITS-1:0] wr_since_pkt;

	integer seed;
	int     err_cnt;
	int     tests_run;
	int     tests_failed;

	always #2 CLK = ~CLK;

	usb_ctrl_bridge #(
		.PINPOL("NEGATIVE")
	) usb_ctrl_bridge_i (
		.CLK        (CLK),
		.rst_i      (rst_i),
		.flaga_i    (flaga_i),
		.flagd_i    (flagd_i),
		.sloe_o     (sloe_o),
		.slrd_o     (slrd_o),
		.slwr_o     (slwr_o),
		.pktend_o   (pktend_o),
		.fifoadr_o  (fifoadr_o),
		.fd_io      (fd_io),
		.ctrl_src_i (ctrl_src_i),
		.ctrl_sink_o(ctrl_sink_o)
	);

	// FX2 drives FD only while SLOE is low
	assign fd_io = (sloe_o == 1'b0) ? fd_val : 8'hzz;
	assign ctrl_src_i = '{dat: out_head, empty: out_empty, packet: pkt_open, full: in_full};

	// FX2 endpoint model
	// SLRD pops EP2 only when FLAGA said not empty
	// SLWR pushes FD into EP6
	always @(posedge CLK) begin
		if (slrd_o == 1'b0 && flaga_i == 1'b1) begin
			ep2_q.delete(0);
		end
		if (slwr_o == 1'b0) begin
			ep6_q.push_back(fd_io);
			wr_since_pkt = wr_since_pkt + 1'b1;
			check_addr("fifoadr_o", fifoadr_o, CTRL_OUTBOUND);
		end
		// Packet length is the SLWR count since the last PKTEND
		if (pktend_o == 1'b0) begin
			pkt_lens.push_back(wr_since_pkt);
			wr_since_pkt = '0;
		end
		// FLAGA low means EP2 empty
		flaga_i <= (ep2_q.size() != 0);
		fd_val  <= (ep2_q.size() != 0) ? ep2_q[0] : 8'h00;
	end

	// Local FIFO model with first-word-fall-through on the outbound side
	always @(posedge CLK) begin
		if (ctrl_sink_o.wr === 1'b1) begin
			in_cap.push_back(ctrl_sink_o.dat);
		end
		if (ctrl_sink_o.rd === 1'b1 && out_empty == 1'b0) begin
			out_q.delete(0);
		end
		out_empty <= (out_q.size() == 0);
		out_head  <= (out_q.size() != 0) ? out_q[0] : 8'h00;
	end

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("error %s: got %h, expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_len(input string name, input logic [LEN_BITS-1:0] got,
		input logic [LEN_BITS-1:0] exp);
		if (got !== exp) begin
			$display("error %s: got %h, expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_addr(input string name, input fifo_addr_e got, input fifo_addr_e exp);
		if (got !== exp) begin
			$display("error %s: got %h, expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %s: got %h, expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic count_error(input string what, input int got, input int exp);
		$display("%s is %0d where %0d was expected", what, got, exp);
		err_cnt++;
	endtask

	// Byte-by-byte compare of got_q against exp_q
	task automatic compare_stream(input string name);
		int n;
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		if (got_q.size() != exp_q.size()) begin
			count_error({name, " byte count"}, got_q.size(), exp_q.size());
		end
		for (int i = 0; i < n; i++) begin
			check_byte(name, got_q[i], exp_q[i]);
		end
	endtask

	// Rest means every strobe inactive and the address parked
	function automatic bit wait_done(input wait_e kind, input int n);
		case (kind)
			WAIT_INBOUND: return in_cap.size() >= n;
			WAIT_PKTEND:  return pkt_lens.size() >= n;
			default: return slrd_o === 1'b1 && slwr_o === 1'b1 && pktend_o === 1'b1 &&
				sloe_o === 1'b1 && fifoadr_o === EVENT_INBOUND;
		endcase
	endfunction

	// Drives on the rising edge and samples on the falling edge
	task automatic wait_until(input wait_e kind, input int n, input bit toggle_full,
		input string what);
		int cyc;
		cyc = 0;
		while (!wait_done(kind, n) && cyc < TIMEOUT) begin
			@(posedge CLK);
			if (toggle_full) begin
				// Full for two cycles out of every five
				in_full <= (cyc % 5) < 2;
			end
			@(negedge CLK);
			cyc++;
		end
		if (!wait_done(kind, n)) begin
			$display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name, input int errs);
		tests_run++;
		if (err_cnt == errs) begin
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, err_cnt - errs);
		end
	endtask

	task automatic test_reset();
		int errs;
		errs = err_cnt;
		@(negedge CLK);
		check_level("slrd_o", slrd_o, 1'b1);
		check_level("slwr_o", slwr_o, 1'b1);
		check_level("pktend_o", pktend_o, 1'b1);
		check_level("sloe_o", sloe_o, 1'b1);
		check_addr("fifoadr_o", fifoadr_o, EVENT_INBOUND);
		check_level("ctrl_sink_o.wr", ctrl_sink_o.wr, 1'b0);
		check_level("ctrl_sink_o.rd", ctrl_sink_o.rd, 1'b0);
		finish_test("reset state", errs);
	endtask

	// EP2 bytes must land in the inbound FIFO once each and in order
	task automatic test_inbound(input string name, input int n, input bit toggle_full);
		int errs;
		errs = err_cnt;
		in_cap.delete();
		exp_q.delete();
		@(negedge CLK);
		for (int i = 0; i < n; i++) begin
			exp_q.push_back(8'($random(seed)));
		end
		ep2_q = exp_q;
		wait_until(WAIT_INBOUND, n, toggle_full, "inbound bytes");
		@(posedge CLK);
		in_full <= 1'b0;
		@(negedge CLK);
		wait_until(WAIT_REST, 0, 1'b0, "the bridge to go idle after a read");
		got_q = in_cap;
		compare_stream("ctrl_sink_o.dat");
		finish_test(name, errs);
	endtask

	// Closed packets are cut at 512 bytes and the rest goes out with PKTEND
	task automatic test_outbound(input string name, input int n);
		int errs;
		int npkt;
		int rem;
		errs = err_cnt;
		npkt = (n + PKT_MAX_BYTES - 1) / PKT_MAX_BYTES;
		ep6_q.delete();
		pkt_lens.delete();
		exp_q.delete();
		@(negedge CLK);
		for (int i = 0; i < n; i++) begin
			exp_q.push_back(8'($random(seed)));
		end
		out_q = exp_q;
		wait_until(WAIT_PKTEND, npkt, 1'b0, "PKTEND");
		wait_until(WAIT_REST, 0, 1'b0, "the bridge to go idle after a write");
		if (pkt_lens.size() != npkt) begin
			count_error("PKTEND count", pkt_lens.size(), npkt);
		end
		rem = n;
		for (int k = 0; k < pkt_lens.size() && k < npkt; k++) begin
			check_len("pktend length", pkt_lens[k],
				LEN_BITS'((rem > PKT_MAX_BYTES) ? PKT_MAX_BYTES : rem));
			rem = rem - PKT_MAX_BYTES;
		end
		got_q = ep6_q;
		compare_stream("fd_io");
		finish_test(name, errs);
	endtask

	initial begin
		seed         = 86791;
		err_cnt      = 0;
		tests_run    = 0;
		tests_failed = 0;
		wr_since_pkt = '0;
		rst_i     <= 1'b1;
		flaga_i   <= 1'b0;
		flagd_i   <= 1'b1;
		fd_val    <= 8'h00;
		out_head  <= 8'h00;
		out_empty <= 1'b1;
		pkt_open  <= 1'b0;
		in_full   <= 1'b0;
		repeat (10) @(posedge CLK);
		rst_i <= 1'b0;

		test_reset();
		test_inbound("inbound read", 20, 1'b0);
		test_inbound("inbound back-pressure", 40, 1'b1);
		test_outbound("short outbound packet", 30);
		test_outbound("long outbound transfer", 600);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== list.f ====
fx2_pkg.sv
usb_ctrl_pkg.sv
fx2_pin_io.sv
usb_write_packetizer.sv
usb_txn_sequencer.sv
usb_ctrl_bridge.sv
tb_usb_ctrl_bridge.sv
